// ==== logic/csi_cfg_pkg.sv ====
`default_nettype none

package csi_cfg_pkg;

	// link geometry, two lanes at gear 8
	localparam int NUM_LANES = 2;
	localparam int BYTE_W = 8;   // bits per lane byte

	// raw10 packing, 4 pixels share 5 bytes
	localparam int PIXEL_W = 10;
	localparam int GROUP_PIXELS = 4;
	localparam int GROUP_BYTES = 5;

endpackage

`default_nettype wire

// ==== logic/csi_proto_pkg.sv ====
`default_nettype none

package csi_proto_pkg;

	// lane sync pattern, seen once per lane ahead of every packet
	localparam logic [7:0] SYNC_BYTE = 8'hB8;

	// data types in use
	localparam logic [5:0] DT_FRAME_START = 6'h00;
	localparam logic [5:0] DT_RAW10 = 6'h2B;
	localparam logic [5:0] LONG_PACKET_MIN = 6'h10; // 0x00..0x0f are short packets

	localparam int HEADER_BYTES = 4;

	// field layout, msb first so that the data identifier sits in byte 0
	typedef struct packed {
		logic [7:0] ecc;         // byte 3, not checked
		logic [15:0] word_count; // bytes 1 and 2, low byte first
		logic [1:0] vc;          // virtual channel
		logic [5:0] data_type;
	} csi_header_fields_t;

	// one header word, filled byte by byte and read back as fields
	typedef union packed {
		logic [HEADER_BYTES-1:0][7:0] bytes; // index = arrival order
		csi_header_fields_t fields;
	} csi_header_u;

endpackage

`default_nettype wire

// ==== logic/csi_byte_aligner.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi_byte_aligner (
	input wire clk_i,
	input wire rst_n_i,
	input wire line_reset_i,
	input wire [csi_cfg_pkg::BYTE_W-1:0] byte_i,
	output logic [csi_cfg_pkg::BYTE_W-1:0] byte_o,
	output logic byte_valid_o
);

	localparam int BW = csi_cfg_pkg::BYTE_W;
	localparam int OFF_W = $clog2(BW);

	logic [BW-1:0] curr_q;   // newest byte
	logic [BW-1:0] prev_q;   // byte before it
	logic [2*BW-1:0] window; // bits in arrival order, lsb oldest
	logic hit;
	logic [OFF_W-1:0] hit_off;
	logic [OFF_W-1:0] off_q;
	logic locked_q;

	assign window = {curr_q, prev_q};

	// every candidate byte ends inside curr_q, so each data byte
	// completes with the same register and latency does not depend on offset
	always_comb
	begin
		hit = 1'b0;
		hit_off = '0;
		for (int k = BW - 1; k >= 0; k--) // downward, lowest offset wins
		begin
			if (window[k + 1 +: BW] == csi_proto_pkg::SYNC_BYTE)
			begin
				hit = 1'b1;
				hit_off = OFF_W'(k);
			end
		end
	end

	// input pipeline, feeds the search so it is cleared
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			curr_q <= '0;
			prev_q <= '0;
		end
		else
		begin
			curr_q <= byte_i;
			prev_q <= curr_q;
		end
	end

	// lock on first hit, hold until the line reset
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			locked_q <= 1'b0;
			off_q <= '0;
			byte_valid_o <= 1'b0;
		end
		else if (line_reset_i)
		begin
			locked_q <= 1'b0;
			byte_valid_o <= 1'b0;
		end
		else
		begin
			if (!locked_q && hit)
			begin
				locked_q <= 1'b1;
				off_q <= hit_off;
			end
			byte_valid_o <= locked_q; // first valid byte follows the sync byte
		end
	end

	always_ff @(posedge clk_i)
	begin
		byte_o <= window[off_q + 1 +: BW];
	end

endmodule

`default_nettype wire

// ==== logic/csi_lane_aligner.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi_lane_aligner #(
	parameter int MAX_SKEW = 3 // cycles, at least 1
) (
	input wire clk_i,
	input wire rst_n_i,
	input wire line_reset_i,
	input wire [csi_cfg_pkg::NUM_LANES-1:0] bytes_valid_i,
	input wire [csi_cfg_pkg::NUM_LANES*csi_cfg_pkg::BYTE_W-1:0] bytes_i,
	output logic lane_valid_o,
	output logic [csi_cfg_pkg::NUM_LANES*csi_cfg_pkg::BYTE_W-1:0] lane_bytes_o
);

	localparam int LANES = csi_cfg_pkg::NUM_LANES;
	localparam int BW = csi_cfg_pkg::BYTE_W;
	localparam int CNT_W = $clog2(MAX_SKEW + 1);

	logic [CNT_W-1:0] cnt_q;         // cycles since the first lane went valid
	logic [LANES-1:0] seen_q;
	logic [CNT_W-1:0] arr_q [LANES]; // arrival cycle per lane
	logic [CNT_W-1:0] dly_q [LANES];
	logic [CNT_W-1:0] dly_c [LANES];
	logic aligned_q;
	logic fail_q;                    // skew too large, wait for line reset
	logic [BW-1:0] sr_q [LANES][MAX_SKEW];

	// delay = latest arrival minus own arrival; a lane arriving now gets 0
	always_comb
	begin
		for (int l = 0; l < LANES; l++)
		begin
			if (aligned_q)
				dly_c[l] = dly_q[l];
			else if (seen_q[l])
				dly_c[l] = cnt_q - arr_q[l];
			else
				dly_c[l] = '0;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i || line_reset_i)
		begin
			cnt_q <= '0;
			seen_q <= '0;
			aligned_q <= 1'b0;
			fail_q <= 1'b0;
			for (int l = 0; l < LANES; l++)
			begin
				arr_q[l] <= '0;
				dly_q[l] <= '0;
			end
		end
		else if (!aligned_q && !fail_q && (|bytes_valid_i))
		begin
			for (int l = 0; l < LANES; l++)
			begin
				if (bytes_valid_i[l] && !seen_q[l])
				begin
					seen_q[l] <= 1'b1;
					arr_q[l] <= cnt_q;
				end
			end
			if (&bytes_valid_i)
			begin
				aligned_q <= 1'b1;
				dly_q <= dly_c; // freeze taps
			end
			else if (cnt_q == CNT_W'(MAX_SKEW))
				fail_q <= 1'b1;
			else
				cnt_q <= cnt_q + 1'b1;
		end
	end

	// per-lane history, sr_q[l][0] is one cycle old
	always_ff @(posedge clk_i)
	begin
		for (int l = 0; l < LANES; l++)
		begin
			sr_q[l][0] <= bytes_i[l*BW +: BW];
			for (int s = 1; s < MAX_SKEW; s++)
				sr_q[l][s] <= sr_q[l][s-1];
		end
	end

	// valid in the same cycle the last lane arrives
	assign lane_valid_o = (&bytes_valid_i) && !fail_q;

	always_comb
	begin
		for (int l = 0; l < LANES; l++)
		begin
			if (dly_c[l] == '0)
				lane_bytes_o[l*BW +: BW] = bytes_i[l*BW +: BW]; // latest lane direct
			else
				lane_bytes_o[l*BW +: BW] = sr_q[l][dly_c[l] - 1'b1];
		end
	end

endmodule

`default_nettype wire

// ==== logic/csi_packet_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi_packet_decoder (
	input wire clk_i,
	input wire rst_n_i,
	input wire line_reset_i,
	input wire lane_valid_i,
	input wire [csi_cfg_pkg::NUM_LANES*csi_cfg_pkg::BYTE_W-1:0] lane_bytes_i,
	output logic frame_start_o,
	output logic [csi_cfg_pkg::NUM_LANES*csi_cfg_pkg::BYTE_W-1:0] payload_o,
	output logic payload_valid_o,
	output logic line_valid_o
);

	localparam int LANES = csi_cfg_pkg::NUM_LANES;
	localparam int BW = csi_cfg_pkg::BYTE_W;

	typedef enum logic [1:0] {
		ST_HDR0, // data id + word count low
		ST_HDR1, // word count high + ecc
		ST_DATA, // long packet payload
		ST_DONE  // idle until line reset
	} state_t;

	state_t state_q;
	csi_proto_pkg::csi_header_u hdr_q; // first header word
	csi_proto_pkg::csi_header_u hdr_c; // complete header during ST_HDR1
	logic [15:0] wc_q;                 // bytes left in payload
	logic raw_q;                       // payload is forwarded

	// upper header bytes come straight from the second word
	always_comb
	begin
		hdr_c = hdr_q;
		for (int l = 0; l < LANES; l++)
			hdr_c.bytes[LANES + l] = lane_bytes_i[l*BW +: BW];
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i || line_reset_i)
		begin
			state_q <= ST_HDR0;
			wc_q <= '0;
			raw_q <= 1'b0;
			frame_start_o <= 1'b0;
			payload_valid_o <= 1'b0;
			line_valid_o <= 1'b0;
		end
		else
		begin
			frame_start_o <= 1'b0;
			payload_valid_o <= 1'b0;
			line_valid_o <= payload_valid_o; // one extra stage, lines up with depacker output
			case (state_q)
				ST_HDR0:
					if (lane_valid_i)
						state_q <= ST_HDR1;
				ST_HDR1:
					if (lane_valid_i)
					begin
						if (hdr_c.fields.data_type == csi_proto_pkg::DT_FRAME_START)
						begin
							frame_start_o <= 1'b1;
							state_q <= ST_DONE;
						end
						else if (hdr_c.fields.data_type >= csi_proto_pkg::LONG_PACKET_MIN &&
							hdr_c.fields.word_count != '0)
						begin
							state_q <= ST_DATA;
							wc_q <= hdr_c.fields.word_count;
							raw_q <= (hdr_c.fields.data_type == csi_proto_pkg::DT_RAW10);
						end
						else
							state_q <= ST_DONE; // other short packets
					end
				ST_DATA:
					if (lane_valid_i)
					begin
						payload_valid_o <= raw_q; // other types counted off silently
						wc_q <= wc_q - 16'(LANES);
						if (wc_q <= 16'(LANES))
							state_q <= ST_DONE;
					end
				default: ;
			endcase
		end
	end

	// header bytes and payload word, no reset needed
	always_ff @(posedge clk_i)
	begin
		if (state_q == ST_HDR0 && lane_valid_i)
			for (int l = 0; l < LANES; l++)
				hdr_q.bytes[l] <= lane_bytes_i[l*BW +: BW];
		payload_o <= lane_bytes_i;
	end

endmodule

`default_nettype wire

// ==== logic/csi_raw10_depacker.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi_raw10_depacker (
	input wire clk_i,
	input wire rst_n_i,
	input wire [csi_cfg_pkg::NUM_LANES*csi_cfg_pkg::BYTE_W-1:0] payload_i,
	input wire payload_valid_i,
	output logic [csi_cfg_pkg::GROUP_PIXELS*csi_cfg_pkg::PIXEL_W-1:0] pixels_o,
	output logic pixel_valid_o
);

	localparam int LANES = csi_cfg_pkg::NUM_LANES;
	localparam int BW = csi_cfg_pkg::BYTE_W;
	localparam int PW = csi_cfg_pkg::PIXEL_W;
	localparam int GB = csi_cfg_pkg::GROUP_BYTES;
	localparam int LSB_W = PW - BW;         // low bits packed in 5th byte
	localparam int BUF_N = GB - 1;          // most bytes ever left pending
	localparam int CAT_N = BUF_N + LANES;   // pending plus new
	localparam int FILL_W = $clog2(CAT_N + 1);

	logic [BUF_N*BW-1:0] buf_q;  // pending bytes with byte 0 oldest and unused bytes zero
	logic [FILL_W-1:0] fill_q;
	logic [CAT_N*BW-1:0] cat_c;  // pending bytes with new word appended
	logic [FILL_W-1:0] sum_c;
	logic group_done;

	always_comb
	begin
		cat_c = {{(LANES*BW){1'b0}}, buf_q} |
			({{(BUF_N*BW){1'b0}}, payload_i} << (fill_q * BW));
		sum_c = fill_q + FILL_W'(LANES);
		group_done = (sum_c >= FILL_W'(GB)); // 5th byte of a group is in
	end

	// fill count and strobe
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			fill_q <= '0;
			pixel_valid_o <= 1'b0;
		end
		else if (!payload_valid_i)
		begin
			fill_q <= '0; // gap between lines
			pixel_valid_o <= 1'b0;
		end
		else
		begin
			pixel_valid_o <= group_done;
			fill_q <= group_done ? sum_c - FILL_W'(GB) : sum_c;
		end
	end

	// byte buffer emptied on any gap so the merge above sees zeros
	always_ff @(posedge clk_i)
	begin
		if (!payload_valid_i)
			buf_q <= '0;
		else if (group_done)
			buf_q <= (BUF_N*BW)'(cat_c >> (GB * BW)); // carry leftover byte
		else
			buf_q <= cat_c[BUF_N*BW-1:0];
	end

	// pixel n is byte n shifted up with lsbs from bits 2n+1:2n of byte 4
	always_ff @(posedge clk_i)
	begin
		if (payload_valid_i && group_done)
			for (int n = 0; n < csi_cfg_pkg::GROUP_PIXELS; n++)
				pixels_o[n*PW +: PW] <= {cat_c[n*BW +: BW],
					cat_c[(GB-1)*BW + n*LSB_W +: LSB_W]};
	end

endmodule

`default_nettype wire

// ==== logic/csi_rx_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi_rx_core #(
	parameter int LANE_SKEW_MAX = 3 // tolerated lane skew in byte clocks
) (
	input wire clk_i,   // byte clock
	input wire rst_n_i,
	input wire [csi_cfg_pkg::NUM_LANES*csi_cfg_pkg::BYTE_W-1:0] lane_bytes_i,
	input wire lp_data_i, // lane 0 lp level
	output logic frame_start_o,
	output logic line_valid_o,
	output logic [csi_cfg_pkg::GROUP_PIXELS*csi_cfg_pkg::PIXEL_W-1:0] pixels_o,
	output logic pixel_valid_o
);

	localparam int LANES = csi_cfg_pkg::NUM_LANES;
	localparam int BW = csi_cfg_pkg::BYTE_W;

	logic line_reset_q;             // rises one cycle after lp, held through lp
	logic [LANES-1:0] byte_valid;
	logic [LANES*BW-1:0] byte_aligned;
	logic lane_valid;
	logic [LANES*BW-1:0] lane_aligned;
	logic [LANES*BW-1:0] payload;
	logic payload_valid;

	// line reset from the registered lp level
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			line_reset_q <= 1'b0;
		else
			line_reset_q <= lp_data_i;
	end

	for (genvar g = 0; g < LANES; g++)
	begin : gen_lane
		csi_byte_aligner byte_aligner_ins (
			.clk_i(clk_i), .rst_n_i(rst_n_i), .line_reset_i(line_reset_q),
			.byte_i(lane_bytes_i[g*BW +: BW]),
			.byte_o(byte_aligned[g*BW +: BW]),
			.byte_valid_o(byte_valid[g]));
	end

	csi_lane_aligner #(.MAX_SKEW(LANE_SKEW_MAX)) lane_aligner_ins0 (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .line_reset_i(line_reset_q),
		.bytes_valid_i(byte_valid), .bytes_i(byte_aligned),
		.lane_valid_o(lane_valid), .lane_bytes_o(lane_aligned));

	csi_packet_decoder packet_decoder_ins0 (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .line_reset_i(line_reset_q),
		.lane_valid_i(lane_valid), .lane_bytes_i(lane_aligned),
		.frame_start_o(frame_start_o), .payload_o(payload),
		.payload_valid_o(payload_valid), .line_valid_o(line_valid_o));

	csi_raw10_depacker raw10_depacker_ins0 (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.payload_i(payload), .payload_valid_i(payload_valid),
		.pixels_o(pixels_o), .pixel_valid_o(pixel_valid_o));

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial
	begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o; // 20 ns byte clock
	end

	initial
	begin
		rst_n_o = 1'b0;
		repeat (8) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1; // released away from the sampling edge
	end

endmodule

`default_nettype wire

// ==== sim/csi_rx_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi_rx_checker (
	input wire clk_i,
	input wire rst_n_i,
	input wire frame_start_i,
	input wire line_valid_i,
	input wire pixel_valid_i,
	input wire [csi_cfg_pkg::GROUP_PIXELS*csi_cfg_pkg::PIXEL_W-1:0] pixels_i
);

	localparam int PW = csi_cfg_pkg::PIXEL_W;

	int errors = 0;
	int tests_pass = 0;
	int tests_fail = 0;
	int err_base;              // error count when the test began
	int fs_cnt;
	int grp_cnt;
	logic lv_seen;
	logic [PW-1:0] exp_q [$];  // expected pixels, pixel 0 of each group first
	logic [PW-1:0] exp_v;

	task push_pixel(input logic [PW-1:0] v);
		exp_q.push_back(v);
	endtask

	task start_test();
		fs_cnt = 0;
		grp_cnt = 0;
		lv_seen = 1'b0;
		err_base = errors;
	endtask

	// outputs are registered, stable at the falling edge
	always @(negedge clk_i)
	begin
		if (rst_n_i)
		begin
			if (frame_start_i)
				fs_cnt++;
			if (line_valid_i)
				lv_seen = 1'b1;
			if (pixel_valid_i)
			begin
				grp_cnt++;
				if (!line_valid_i)
				begin
					$display("pixel group at %0t arrived while line_valid_o was low", $time);
					errors++;
				end
				if (exp_q.size() < csi_cfg_pkg::GROUP_PIXELS)
				begin
					$display("unexpected pixel group at %0t, none was left to compare", $time);
					errors++;
				end
				else
					for (int n = 0; n < csi_cfg_pkg::GROUP_PIXELS; n++)
					begin
						exp_v = exp_q.pop_front();
						if (pixels_i[n*PW +: PW] !== exp_v)
						begin
							$display("ERROR at %0t: pixels_o[%0d] expected %h got %h",
								$time, n, exp_v, pixels_i[n*PW +: PW]);
							errors++;
						end
					end
			end
		end
	end

	task end_test(input int idx, input int exp_fs, input int exp_groups);
		if (fs_cnt != exp_fs)
		begin
			$display("ERROR at %0t: frame_start_o pulses expected %0d got %0d",
				$time, exp_fs, fs_cnt);
			errors++;
		end
		if (grp_cnt != exp_groups)
		begin
			$display("ERROR at %0t: pixel_valid_o groups expected %0d got %0d",
				$time, exp_groups, grp_cnt);
			errors++;
		end
		if (exp_q.size() != 0)
		begin
			$display("test %0d left expected pixel groups that never came out", idx);
			exp_q.delete();
			errors++;
		end
		if (exp_groups == 0 && lv_seen)
		begin
			$display("line_valid_o went high in test %0d with no RAW10 line sent", idx);
			errors++;
		end
		if (errors == err_base)
		begin
			tests_pass++;
			$display("test %0d: pass, %0d groups, %0d frame starts", idx, grp_cnt, fs_cnt);
		end
		else
		begin
			tests_fail++;
			$display("test %0d: FAIL, %0d errors", idx, errors - err_base);
		end
	endtask

	task print_summary();
		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_pass + tests_fail, tests_pass, tests_fail, errors);
	endtask

endmodule

`default_nettype wire

// ==== sim/csi_rx_core_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi_rx_core_props (
	input wire clk_i,
	input wire rst_n_i,
	input wire frame_start_o,
	input wire line_valid_o,
	input wire pixel_valid_o
);

	// frame start is a one cycle strobe
	a_fs_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		frame_start_o |=> !frame_start_o)
		else $error("frame_start_o held longer than one cycle");

	a_fs_not_in_line: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(frame_start_o && line_valid_o))
		else $error("frame_start_o during line_valid_o");

	a_pixel_in_line: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pixel_valid_o |-> line_valid_o)
		else $error("pixel_valid_o outside line_valid_o");

	// async reset clears all strobes
	a_reset_quiet: assert property (@(posedge clk_i)
		!rst_n_i |-> (!frame_start_o && !line_valid_o && !pixel_valid_o))
		else $error("outputs active during reset");

endmodule

`default_nettype wire

// ==== sim/tb_csi_rx_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_csi_rx_core;

	localparam int LANES = csi_cfg_pkg::NUM_LANES;
	localparam int BW = csi_cfg_pkg::BYTE_W;
	localparam int LP_CYC = 4;    // low-power period before each packet
	localparam int LEAD = 4;      // filler bytes ahead of the sync byte
	localparam int TRAIL = 12;    // idle cycles to flush the pipeline
	localparam int HEAD_CYC = 9;  // filler, max skew, offset and sync bound

	logic clk;
	logic rst_n;
	logic [LANES*BW-1:0] lane_bytes;
	logic lp_data;
	wire frame_start;
	wire line_valid;
	wire pixel_valid;
	wire [csi_cfg_pkg::GROUP_PIXELS*csi_cfg_pkg::PIXEL_W-1:0] pixels;

	logic [15:0] mem [0:1023]; // data file words
	int rd;
	int seed;
	int total_cycles;
	int ntests;
	logic [1023:0] bits [LANES]; // serialized lane streams, lsb first
	int blen [LANES];
	logic [7:0] hist [LANES];    // last 8 bits per lane, for the sync check
	logic [7:0] pkt [0:63];

	tb_clock_gen clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

	csi_rx_core #(.LANE_SKEW_MAX(3)) dut_i (
		.clk_i(clk), .rst_n_i(rst_n), .lane_bytes_i(lane_bytes), .lp_data_i(lp_data),
		.frame_start_o(frame_start), .line_valid_o(line_valid),
		.pixels_o(pixels), .pixel_valid_o(pixel_valid));

	csi_rx_checker chk_i (
		.clk_i(clk), .rst_n_i(rst_n), .frame_start_i(frame_start),
		.line_valid_i(line_valid), .pixel_valid_i(pixel_valid), .pixels_i(pixels));

	bind csi_rx_core csi_rx_core_props props_i (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .frame_start_o(frame_start_o),
		.line_valid_o(line_valid_o), .pixel_valid_o(pixel_valid_o));

	function automatic int take();
		take = mem[rd];
		rd++;
	endfunction

	// walk the file once to size the watchdog
	function automatic int count_cycles();
		int p;
		int cyc;
		int np;
		int ng;
		p = 1;
		cyc = 0;
		for (int t = 0; t < mem[0]; t++)
		begin
			np = mem[p];
			p++;
			for (int k = 0; k < np; k++)
			begin
				cyc += LP_CYC + HEAD_CYC + mem[p+4] / 2 + TRAIL;
				p += 5 + mem[p+4];
			end
			ng = mem[p];
			p += 2 + 4 * ng;
		end
		count_cycles = cyc;
	endfunction

	task automatic add_bit(input int l, input logic b);
		bits[l][blen[l]] = b;
		hist[l] = {b, hist[l][7:1]};
		blen[l]++;
	endtask

	// random bit, redrawn if it would complete a sync byte
	task automatic add_filler(input int l);
		logic b;
		logic [7:0] cand;
		do
		begin
			b = 1'($random(seed));
			cand = {b, hist[l][7:1]};
		end while (cand == csi_proto_pkg::SYNC_BYTE);
		add_bit(l, b);
	endtask

	task automatic add_byte(input int l, input logic [7:0] v);
		for (int i = 0; i < 8; i++)
			add_bit(l, v[i]);
	endtask

	task automatic send_packet();
		int off [LANES];
		int skew [LANES];
		int nb;
		for (int l = 0; l < LANES; l++)
			off[l] = take();
		for (int l = 0; l < LANES; l++)
			skew[l] = take();
		nb = take();
		for (int i = 0; i < nb; i++)
			pkt[i] = 8'(take());
		for (int l = 0; l < LANES; l++)
		begin
			bits[l] = '0; // zeros past the end look like idle
			blen[l] = 0;
			hist[l] = '0;
			for (int i = 0; i < (LEAD + skew[l]) * 8 + off[l]; i++)
				add_filler(l);
			add_byte(l, csi_proto_pkg::SYNC_BYTE);
			for (int i = l; i < nb; i += LANES) // bytes dealt lane by lane
				add_byte(l, pkt[i]);
		end
		for (int c = 0; c < LP_CYC; c++)
		begin
			@(negedge clk);
			lp_data = 1'b1;
			lane_bytes = '0;
		end
		for (int c = 0; c < HEAD_CYC + nb / 2 + TRAIL; c++)
		begin
			@(negedge clk);
			lp_data = 1'b0;
			lane_bytes = {bits[1][c*BW +: BW], bits[0][c*BW +: BW]};
		end
	endtask

	// expected section follows the packets, so look ahead for it
	task automatic run_test(input int idx);
		int np;
		int p;
		int ng;
		int nfs;
		np = take();
		p = rd;
		for (int k = 0; k < np; k++)
			p += 5 + mem[p+4];
		ng = mem[p];
		chk_i.start_test();
		for (int i = 0; i < 4 * ng; i++)
			chk_i.push_pixel(10'(mem[p+1+i]));
		nfs = mem[p+1+4*ng];
		for (int k = 0; k < np; k++)
			send_packet();
		rd = p + 2 + 4 * ng;
		chk_i.end_test(idx, nfs, ng);
	endtask

	initial
	begin
		seed = 8;
		lane_bytes = '0;
		lp_data = 1'b1;
		rd = 0;
		$readmemh("sim/csi_rx_input.txt", mem);
		total_cycles = count_cycles();
		ntests = take();
		fork
			begin
				#(2 * total_cycles * 20 + 1000);
				$display("timeout: run passed the limit for %0d stimulus cycles", total_cycles);
				$display("Simulation failed");
				$finish;
			end
		join_none
		wait (rst_n == 1'b1);
		for (int t = 0; t < ntests; t++)
			run_test(t + 1);
		chk_i.print_summary();
		if (chk_i.errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== csi_rx_core.f ====
logic/csi_cfg_pkg.sv
logic/csi_proto_pkg.sv
logic/csi_byte_aligner.sv
logic/csi_lane_aligner.sv
logic/csi_packet_decoder.sv
logic/csi_raw10_depacker.sv
logic/csi_rx_core.sv
sim/tb_clock_gen.sv
sim/csi_rx_checker.sv
sim/csi_rx_core_props.sv
sim/tb_csi_rx_core.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_csi_rx_core -f csi_rx_core.f
	./obj_dir/Vtb_csi_rx_core | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== sim/csi_rx_input.txt ====
// hex words; first word is the test count, then per test: packet count,
// per packet off0 off1 skew0 skew1 nbytes bytes, then groups, 4 pixels each, frame starts
5
// test 1: frame start then one raw10 line, no offset or skew
2
0 0 0 0 4 00 01 00 00
0 0 0 0 E 2B 0A 00 00 11 22 33 44 E4 A5 5A FF 00 1B
2 044 089 0CE 113 297 16A 3FD 000
1
// test 2: bit offsets 3 and 6
1
3 6 0 0 E 2B 0A 00 00 11 22 33 44 E4 A5 5A FF 00 1B
2 044 089 0CE 113 297 16A 3FD 000
0
// test 3: lane 1 late by one cycle, then lane 0 late by two
2
0 0 0 1 E 2B 0A 00 00 11 22 33 44 E4 A5 5A FF 00 1B
0 0 2 0 E 2B 0A 00 00 11 22 33 44 E4 A5 5A FF 00 1B
4 044 089 0CE 113 297 16A 3FD 000
044 089 0CE 113 297 16A 3FD 000
0
// test 4: embedded data long packet, no pixels
1
0 0 0 0 E 12 0A 00 00 11 22 33 44 E4 A5 5A FF 00 1B
0
0
// test 5: two lines with different offsets
2
1 5 0 0 E 2B 0A 00 00 11 22 33 44 E4 A5 5A FF 00 1B
7 2 0 0 E 2B 0A 00 00 11 22 33 44 E4 A5 5A FF 00 1B
4 044 089 0CE 113 297 16A 3FD 000
044 089 0CE 113 297 16A 3FD 000
0
